// File: verif/ptw_stim.txt
# T kind(0 instr 1 load 2 store 3 instr+data) mxr flush_cycle vaddr asid satp_ppn
# P pte_addr pte | E result(0 none 1 itlb 2 dtlb 3 error) vpn is_1g is_2m content
T 0 0 0 0040603000 0011 80000
P 80000008 0000000020000401
P 80001018 0000000020000801
P 80002018 00000000048d1449
E 1 0040603 0 0 00000000048d1449
T 1 0 0 0080001000 0022 80000
P 80000010 0000000030000063
E 2 0080001 1 0 0000000030000063
T 2 0 0 00c0000000 0022 80000
P 80000018 0000000030000047
E 3 0 0 0 0
T 0 0 0 0100000000 0022 80000
P 80000020 0000000030000043
E 3 0 0 0 0
T 1 0 0 0140000000 0022 80000
P 80000028 0000000030000005
E 3 0 0 0 0
T 1 0 0 0040603000 0033 80000
P 80000008 0000000020000401
P 80001018 0000000020000801
P 80002018 0000000020000c01
E 3 0 0 0 0
T 1 0 0 0040600000 0033 80000
P 80000008 0000000020000401
P 80001018 00000000048d1443
E 3 0 0 0 0
T 3 0 0 0080001000 0044 80000
P 80000010 0000000030000063
E 2 0080001 1 0 0000000030000063
T 0 0 3 0040603000 0011 80000
P 80000008 0000000020000401
P 80001018 0000000020000801
P 80002018 00000000048d1449
E 0 0 0 0 0
T 2 0 0 0040600000 0055 80000
P 80000008 0000000020000401
P 80001018 00000000048800c7
E 2 0040600 0 1 00000000048800c7

// File: flist.f
+incdir+include
hdl/sv39_pkg.sv
hdl/ptw_tlb_pkg.sv
hdl/ptw_level_ctrl.sv
hdl/pte_checker.sv
hdl/ptw_addr_path.sv
hdl/ptw_fsm.sv
hdl/ptw_top.sv
verif/tb_ptw.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_ptw, fail if the log reports errors"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing -Iinclude -f flist.f --top-module tb_ptw -o Vtb_ptw
	./obj_dir/Vtb_ptw | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/tb_ptw.sv
// Testbench for the Sv39 page table walker:
// clock and reset, randomized data cache model, stimulus file reader,
// typed compare tasks and the closing report

`timescale 1ns/1ps
`default_nettype none

`include "ptw_macros.svh"

module tb_ptw;

    logic clk_i, rst_ni, flush_i, lsu_is_store_i, mxr_i;
    logic itlb_access_i, dtlb_access_i, mem_gnt_i, mem_rvalid_i;
    logic [`PTW_VLEN-1:0] itlb_vaddr_i, dtlb_vaddr_i;
    logic [`PTW_ASIDW-1:0] asid_i;
    logic [`PTW_PPNW-1:0] satp_ppn_i;
    logic [`PTW_PTEW-1:0] mem_rdata_i;
    logic mem_req_o, mem_tag_valid_o, itlb_update_valid_o, dtlb_update_valid_o;
    logic ptw_error_o, ptw_active_o, walking_instr_o, itlb_miss_o, dtlb_miss_o;
    logic [`PTW_PLEN-1:0] mem_addr_o;
    logic [`PTW_VLEN-1:0] update_vaddr_o;
    ptw_tlb_pkg::tlb_update_t tlb_update_o;

    // memory model state
    logic [31:0] lfsr = 32'hb605_495f;
    logic [`PTW_PLEN-1:0] pair_addr [0:2];
    logic [`PTW_PTEW-1:0] pair_pte [0:2];
    int n_pairs = 0;
    int gnt_wait = -1;
    int rv_cnt = 0;
    logic gnt_prev = 1'b0;
    logic [`PTW_PLEN-1:0] addr_lat;
    int errors = 0;
    int tests = 0;
    int failed = 0;

    ptw_top u_dut (
        .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i),
        .enable_translation_i(1'b1), .en_ld_st_translation_i(1'b1),
        .lsu_is_store_i(lsu_is_store_i), .mxr_i(mxr_i),
        .itlb_access_i(itlb_access_i), .itlb_hit_i(1'b0), .itlb_vaddr_i(itlb_vaddr_i),
        .dtlb_access_i(dtlb_access_i), .dtlb_hit_i(1'b0), .dtlb_vaddr_i(dtlb_vaddr_i),
        .asid_i(asid_i), .satp_ppn_i(satp_ppn_i),
        .mem_req_o(mem_req_o), .mem_gnt_i(mem_gnt_i), .mem_tag_valid_o(mem_tag_valid_o),
        .mem_addr_o(mem_addr_o), .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i),
        .itlb_update_valid_o(itlb_update_valid_o), .dtlb_update_valid_o(dtlb_update_valid_o),
        .tlb_update_o(tlb_update_o), .update_vaddr_o(update_vaddr_o),
        .ptw_error_o(ptw_error_o), .ptw_active_o(ptw_active_o),
        .walking_instr_o(walking_instr_o), .itlb_miss_o(itlb_miss_o), .dtlb_miss_o(dtlb_miss_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Galois LFSR, one step per bit
    function automatic logic [3:0] take_bits(input int n);
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [`PTW_PTEW-1:0] lookup_pte(input logic [`PTW_PLEN-1:0] a);
        for (int i = 0; i < n_pairs; i++) begin
            if (pair_addr[i] == a) return pair_pte[i];
        end
        $display("read from unmapped address %h at %0t", a, $time);
        errors++;
        return '0;
    endfunction

    // ------------------------------------------------------------
    // data cache model: grant after 0..3 cycles, rvalid 1..2 after tag
    // ------------------------------------------------------------
    initial begin
        logic req_s, tag_s;
        logic [`PTW_PLEN-1:0] addr_s;
        forever begin
            @(negedge clk_i);
            req_s = mem_req_o;
            tag_s = mem_tag_valid_o;
            addr_s = mem_addr_o;
            @(posedge clk_i);
            #2;
            mem_gnt_i = 1'b0;
            mem_rvalid_i = 1'b0;
            if (tag_s) rv_cnt = 1 + int'(take_bits(1));
            if (rv_cnt > 0) begin
                rv_cnt--;
                if (rv_cnt == 0) begin
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i = lookup_pte(addr_lat);
                end
            end
            if (!req_s || gnt_prev) begin
                gnt_wait = -1;
                gnt_prev = 1'b0;
            end else begin
                if (gnt_wait < 0) gnt_wait = int'(take_bits(2));
                if (gnt_wait == 0) begin
                    mem_gnt_i = 1'b1;
                    addr_lat = addr_s;
                    gnt_prev = 1'b1;
                end
                gnt_wait--;
            end
        end
    end

    task automatic check_update(input ptw_tlb_pkg::tlb_update_t got,
                                input ptw_tlb_pkg::tlb_update_t exp,
                                input logic [`PTW_VLEN-1:0] got_va,
                                input logic [`PTW_VLEN-1:0] exp_va,
                                input logic got_v, input logic exp_v, input string vname);
        if (got_v !== exp_v) begin
            $display("** Error at %0t: %s got %b expected %b", $time, vname, got_v, exp_v);
            errors++;
        end else if (exp_v) begin
            if (got !== exp) begin
                $display("** Error at %0t: tlb_update_o got %h expected %h", $time, got, exp);
                errors++;
            end
            if (got_va !== exp_va) begin
                $display("** Error at %0t: update_vaddr_o got %h expected %h", $time,
                         got_va, exp_va);
                errors++;
            end
        end
    endtask

    task automatic check_error(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // one walk: miss, optional flush, collect results until idle
    task automatic run_walk(input int kind, input int flush_at, input int res,
                            input ptw_tlb_pkg::tlb_update_t exp,
                            input logic [`PTW_VLEN-1:0] exp_va);
        ptw_tlb_pkg::tlb_update_t got;
        ptw_tlb_pkg::ptw_state_e st;
        logic [`PTW_VLEN-1:0] got_va;
        logic gnt_seen;
        int cyc, n_i, n_d, n_e, rv_cyc, e0;
        cyc = 0;
        n_i = 0;
        n_d = 0;
        n_e = 0;
        rv_cyc = -10;
        e0 = errors;
        got = '0;
        got_va = '0;
        gnt_seen = 1'b0;
        @(posedge clk_i);
        #2;
        itlb_access_i = (kind == 0 || kind == 3);
        dtlb_access_i = (kind != 0);
        @(negedge clk_i);
        check_error(itlb_miss_o, kind == 0, "itlb_miss_o");
        check_error(dtlb_miss_o, kind != 0, "dtlb_miss_o");
        while (cyc < 200) begin
            @(posedge clk_i);
            #2;
            itlb_access_i = 1'b0;
            dtlb_access_i = 1'b0;
            flush_i = (flush_at != 0 && cyc == flush_at);
            @(negedge clk_i);
            cyc++;
            if (cyc == 1) check_error(mem_req_o, 1'b1, "mem_req_o");
            // tag strobe follows every accepted grant by one cycle
            check_error(mem_tag_valid_o, gnt_seen, "mem_tag_valid_o");
            gnt_seen = mem_gnt_i && mem_req_o;
            if (mem_rvalid_i) rv_cyc = cyc;
            if (ptw_active_o && flush_at == 0) check_error(walking_instr_o, kind == 0,
                                                           "walking_instr_o");
            if (itlb_update_valid_o || dtlb_update_valid_o) begin
                got = tlb_update_o;
                got_va = update_vaddr_o;
                if (cyc != rv_cyc + 1) begin
                    $display("update not one cycle after rvalid at %0t", $time);
                    errors++;
                end
            end
            if (ptw_error_o && cyc != rv_cyc + 2) begin
                $display("error pulse not two cycles after rvalid at %0t", $time);
                errors++;
            end
            n_i += int'(itlb_update_valid_o);
            n_d += int'(dtlb_update_valid_o);
            n_e += int'(ptw_error_o);
            if (!ptw_active_o && !flush_i) break;
        end
        flush_i = 1'b0;
        if (cyc >= 200) begin
            st = u_dut.u_fsm.state_q;
            $display("walk did not finish, walker stuck in %s", st.name());
            errors++;
        end
        if (n_i + n_d + n_e > 1) begin
            $display("more than one result pulse in one walk");
            errors++;
        end
        check_update(got, exp, got_va, exp_va, n_i > 0, res == 1, "itlb_update_valid_o");
        check_update(got, exp, got_va, exp_va, n_d > 0, res == 2, "dtlb_update_valid_o");
        check_error(n_e > 0, res == 3, "ptw_error_o");
        // let the cache model drain before the next walk
        cyc = 0;
        while ((ptw_active_o || rv_cnt != 0 || gnt_wait >= 0) && cyc < 50) begin
            @(negedge clk_i);
            cyc++;
        end
        if (cyc >= 50) begin
            $display("walker or memory did not go quiet after the walk");
            errors++;
        end
        tests++;
        if (errors != e0) failed++;
        $display("test %0d kind %0d: %s", tests, kind, (errors == e0) ? "pass" : "fail");
    endtask

    initial begin
        int fd, code, kind, mxr, flush_at, res, is1g, is2m;
        string tok, rest;
        logic [`PTW_VLEN-1:0] va;
        logic [`PTW_PTEW-1:0] content;
        logic [26:0] vpn;
        ptw_tlb_pkg::tlb_update_t exp;
        rst_ni = 1'b0;
        flush_i = 1'b0;
        lsu_is_store_i = 1'b0;
        mxr_i = 1'b0;
        itlb_access_i = 1'b0;
        dtlb_access_i = 1'b0;
        itlb_vaddr_i = '0;
        dtlb_vaddr_i = '0;
        asid_i = '0;
        satp_ppn_i = '0;
        mem_gnt_i = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i = '0;
        kind = 0;
        va = '0;
        repeat (16) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        fd = $fopen("verif/ptw_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    code = $fgets(rest, fd);
                end else if (tok == "T") begin
                    code = $fscanf(fd, "%d %d %d %h %h %h", kind, mxr, flush_at, va,
                                   asid_i, satp_ppn_i);
                    n_pairs = 0;
                    mxr_i = mxr[0];
                    lsu_is_store_i = (kind == 2);
                    itlb_vaddr_i = (kind == 3) ? '0 : va;
                    dtlb_vaddr_i = va;
                end else if (tok == "P") begin
                    code = $fscanf(fd, "%h %h", pair_addr[n_pairs], pair_pte[n_pairs]);
                    n_pairs++;
                end else if (tok == "E") begin
                    code = $fscanf(fd, "%d %h %d %d %h", res, vpn, is1g, is2m, content);
                    exp.vpn = vpn;
                    exp.asid = asid_i;
                    exp.is_1g = is1g[0];
                    exp.is_2m = is2m[0];
                    exp.content = content;
                    run_walk(kind, flush_at, res, exp, va);
                end
            end
            $fclose(fd);
        end
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && tests > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/ptw_top.sv
// Sv39 page table walker top level:
// FSM, level counter, PTE checker and data path

`timescale 1ns/1ps
`default_nettype none

`include "ptw_macros.svh"

module ptw_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     enable_translation_i,
    input  logic                     en_ld_st_translation_i,
    input  logic                     lsu_is_store_i,
    input  logic                     mxr_i,
    input  logic                     itlb_access_i,
    input  logic                     itlb_hit_i,
    input  logic [`PTW_VLEN-1:0]     itlb_vaddr_i,
    input  logic                     dtlb_access_i,
    input  logic                     dtlb_hit_i,
    input  logic [`PTW_VLEN-1:0]     dtlb_vaddr_i,
    input  logic [`PTW_ASIDW-1:0]    asid_i,
    input  logic [`PTW_PPNW-1:0]     satp_ppn_i,
    // data cache read port
    output logic                     mem_req_o,
    input  logic                     mem_gnt_i,
    output logic                     mem_tag_valid_o,
    output logic [`PTW_PLEN-1:0]     mem_addr_o,
    input  logic                     mem_rvalid_i,
    input  logic [`PTW_PTEW-1:0]     mem_rdata_i,
    // TLB update, one record with a strobe per TLB
    output logic                     itlb_update_valid_o,
    output logic                     dtlb_update_valid_o,
    output ptw_tlb_pkg::tlb_update_t tlb_update_o,
    output logic [`PTW_VLEN-1:0]     update_vaddr_o,
    output logic                     ptw_error_o,
    output logic                     ptw_active_o,
    output logic                     walking_instr_o,
    output logic                     itlb_miss_o,
    output logic                     dtlb_miss_o
);

    logic                 start_itlb;
    logic                 start_dtlb;
    logic                 advance;
    logic                 rvalid_q;
    logic                 invalid;
    logic                 is_leaf;
    logic                 leaf_fault;
    logic                 misaligned;
    logic                 last_level;
    sv39_pkg::ptw_level_e level;
    sv39_pkg::pte_t       pte;

    ptw_fsm u_fsm (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .flush_i                (flush_i),
        .enable_translation_i   (enable_translation_i),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .itlb_access_i          (itlb_access_i),
        .itlb_hit_i             (itlb_hit_i),
        .dtlb_access_i          (dtlb_access_i),
        .dtlb_hit_i             (dtlb_hit_i),
        .mem_gnt_i              (mem_gnt_i),
        .rvalid_q_i             (rvalid_q),
        .invalid_i              (invalid),
        .is_leaf_i              (is_leaf),
        .leaf_fault_i           (leaf_fault),
        .misaligned_i           (misaligned),
        .last_level_i           (last_level),
        .start_itlb_o           (start_itlb),
        .start_dtlb_o           (start_dtlb),
        .advance_o              (advance),
        .mem_req_o              (mem_req_o),
        .mem_tag_valid_o        (mem_tag_valid_o),
        .itlb_update_valid_o    (itlb_update_valid_o),
        .dtlb_update_valid_o    (dtlb_update_valid_o),
        .ptw_error_o            (ptw_error_o),
        .ptw_active_o           (ptw_active_o),
        .walking_instr_o        (walking_instr_o),
        .itlb_miss_o            (itlb_miss_o),
        .dtlb_miss_o            (dtlb_miss_o)
    );

    ptw_level_ctrl u_level (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (start_itlb | start_dtlb),
        .advance_i    (advance),
        .level_o      (level),
        .last_level_o (last_level)
    );

    pte_checker u_checker (
        .pte_i        (pte),
        .level_i      (level),
        .is_instr_i   (walking_instr_o),
        .is_store_i   (lsu_is_store_i),
        .mxr_i        (mxr_i),
        .invalid_o    (invalid),
        .is_leaf_o    (is_leaf),
        .leaf_fault_o (leaf_fault),
        .misaligned_o (misaligned)
    );

    ptw_addr_path u_addr (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .start_itlb_i   (start_itlb),
        .start_dtlb_i   (start_dtlb),
        .advance_i      (advance),
        .itlb_vaddr_i   (itlb_vaddr_i),
        .dtlb_vaddr_i   (dtlb_vaddr_i),
        .asid_i         (asid_i),
        .satp_ppn_i     (satp_ppn_i),
        .level_i        (level),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .mem_addr_o     (mem_addr_o),
        .pte_o          (pte),
        .rvalid_q_o     (rvalid_q),
        .update_o       (tlb_update_o),
        .update_vaddr_o (update_vaddr_o)
    );

endmodule

`default_nettype wire

// File: hdl/ptw_fsm.sv
// Walker control FSM:
// miss arbitration with data first, grant and tag-valid sequencing,
// PTE verdict routing, error propagation, flush with read drain

`timescale 1ns/1ps
`default_nettype none

module ptw_fsm (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic enable_translation_i,
    input  logic en_ld_st_translation_i,
    input  logic itlb_access_i,
    input  logic itlb_hit_i,
    input  logic dtlb_access_i,
    input  logic dtlb_hit_i,
    input  logic mem_gnt_i,
    input  logic rvalid_q_i,
    input  logic invalid_i,
    input  logic is_leaf_i,
    input  logic leaf_fault_i,
    input  logic misaligned_i,
    input  logic last_level_i,
    output logic start_itlb_o,
    output logic start_dtlb_o,
    output logic advance_o,
    output logic mem_req_o,
    output logic mem_tag_valid_o,
    output logic itlb_update_valid_o,
    output logic dtlb_update_valid_o,
    output logic ptw_error_o,
    output logic ptw_active_o,
    output logic walking_instr_o,
    output logic itlb_miss_o,
    output logic dtlb_miss_o
);

    ptw_tlb_pkg::ptw_state_e state_q, state_d;
    logic is_instr_q, is_instr_d;
    logic tag_valid_q, tag_valid_d;

    always_comb begin
        state_d             = state_q;
        is_instr_d          = is_instr_q;
        tag_valid_d         = 1'b0;
        start_itlb_o        = 1'b0;
        start_dtlb_o        = 1'b0;
        advance_o           = 1'b0;
        mem_req_o           = 1'b0;
        itlb_update_valid_o = 1'b0;
        dtlb_update_valid_o = 1'b0;
        ptw_error_o         = 1'b0;
        itlb_miss_o         = 1'b0;
        dtlb_miss_o         = 1'b0;

        case (state_q)
            ptw_tlb_pkg::IDLE: begin
                is_instr_d = 1'b0;
                // a fetch miss only gets through when no data access is pending
                if (enable_translation_i && itlb_access_i && !itlb_hit_i && !dtlb_access_i) begin
                    start_itlb_o = 1'b1;
                    itlb_miss_o  = 1'b1;
                    is_instr_d   = 1'b1;
                    state_d      = ptw_tlb_pkg::WAIT_GRANT;
                end else if (en_ld_st_translation_i && dtlb_access_i && !dtlb_hit_i) begin
                    start_dtlb_o = 1'b1;
                    dtlb_miss_o  = 1'b1;
                    state_d      = ptw_tlb_pkg::WAIT_GRANT;
                end
            end
            ptw_tlb_pkg::WAIT_GRANT: begin
                mem_req_o = 1'b1;
                if (mem_gnt_i) begin
                    // the cache expects the tag one cycle after grant
                    tag_valid_d = 1'b1;
                    state_d     = ptw_tlb_pkg::PTE_LOOKUP;
                end
            end
            ptw_tlb_pkg::PTE_LOOKUP: begin
                if (rvalid_q_i) begin
                    if (invalid_i) begin
                        state_d = ptw_tlb_pkg::PROPAGATE_ERROR;
                    end else if (is_leaf_i) begin
                        if (leaf_fault_i || misaligned_i) begin
                            state_d = ptw_tlb_pkg::PROPAGATE_ERROR;
                        end else begin
                            itlb_update_valid_o = is_instr_q;
                            dtlb_update_valid_o = !is_instr_q;
                            state_d             = ptw_tlb_pkg::IDLE;
                        end
                    end else if (last_level_i) begin
                        state_d = ptw_tlb_pkg::PROPAGATE_ERROR;
                    end else begin
                        advance_o = 1'b1;
                        state_d   = ptw_tlb_pkg::WAIT_GRANT;
                    end
                end
            end
            ptw_tlb_pkg::PROPAGATE_ERROR: begin
                ptw_error_o = 1'b1;
                state_d     = ptw_tlb_pkg::IDLE;
            end
            ptw_tlb_pkg::WAIT_RVALID: begin
                if (rvalid_q_i) begin
                    state_d = ptw_tlb_pkg::IDLE;
                end
            end
            default: begin
                state_d = ptw_tlb_pkg::IDLE;
            end
        endcase

        // ------------------------------------------------------------
        // flush
        // ------------------------------------------------------------
        // a read already granted must still return before going idle
        if (flush_i) begin
            start_itlb_o        = 1'b0;
            start_dtlb_o        = 1'b0;
            itlb_miss_o         = 1'b0;
            dtlb_miss_o         = 1'b0;
            advance_o           = 1'b0;
            itlb_update_valid_o = 1'b0;
            dtlb_update_valid_o = 1'b0;
            ptw_error_o         = 1'b0;
            if ((state_q == ptw_tlb_pkg::PTE_LOOKUP && !rvalid_q_i) ||
                (state_q == ptw_tlb_pkg::WAIT_GRANT && mem_gnt_i)) begin
                state_d = ptw_tlb_pkg::WAIT_RVALID;
            end else begin
                state_d = ptw_tlb_pkg::IDLE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= ptw_tlb_pkg::IDLE;
            is_instr_q  <= 1'b0;
            tag_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            is_instr_q  <= is_instr_d;
            tag_valid_q <= tag_valid_d;
        end
    end

    assign mem_tag_valid_o = tag_valid_q;
    assign ptw_active_o    = (state_q != ptw_tlb_pkg::IDLE);
    assign walking_instr_o = is_instr_q;

endmodule

`default_nettype wire

// File: hdl/ptw_addr_path.sv
// Walker data path:
// latched miss address and ASID, PTE pointer generation,
// registered read data, global bit accumulation, TLB update record

`timescale 1ns/1ps
`default_nettype none

`include "ptw_macros.svh"

module ptw_addr_path (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    start_itlb_i,
    input  logic                    start_dtlb_i,
    input  logic                    advance_i,
    input  logic [`PTW_VLEN-1:0]    itlb_vaddr_i,
    input  logic [`PTW_VLEN-1:0]    dtlb_vaddr_i,
    input  logic [`PTW_ASIDW-1:0]   asid_i,
    input  logic [`PTW_PPNW-1:0]    satp_ppn_i,
    input  sv39_pkg::ptw_level_e    level_i,
    input  logic                    mem_rvalid_i,
    input  logic [`PTW_PTEW-1:0]    mem_rdata_i,
    output logic [`PTW_PLEN-1:0]    mem_addr_o,
    output sv39_pkg::pte_t          pte_o,
    output logic                    rvalid_q_o,
    output ptw_tlb_pkg::tlb_update_t update_o,
    output logic [`PTW_VLEN-1:0]    update_vaddr_o
);

    logic [`PTW_VLEN-1:0]  vaddr_q;
    logic [`PTW_ASIDW-1:0] asid_q;
    logic [`PTW_PLEN-1:0]  pptr_q;
    logic [8:0]            next_idx;
    logic [`PTW_VLEN-1:0]  start_vaddr;
    sv39_pkg::pte_word_u   rdata_q;
    logic                  rvalid_q;
    logic                  global_q;
    sv39_pkg::pte_t        leaf_pte;

    assign start_vaddr = start_dtlb_i ? dtlb_vaddr_i : itlb_vaddr_i;

    // VPN slice for the table one level below the current one
    always_comb begin
        case (level_i)
            sv39_pkg::LVL1: next_idx = vaddr_q[29:21];
            default:        next_idx = vaddr_q[20:12];
        endcase
    end

    // ------------------------------------------------------------
    // request and pointer registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (start_itlb_i || start_dtlb_i) begin
            vaddr_q <= start_vaddr;
            asid_q  <= asid_i;
            // root table entry selected by VPN[2]
            pptr_q  <= {satp_ppn_i, start_vaddr[38:30], 3'b000};
        end else if (advance_i) begin
            pptr_q  <= {rdata_q.pte.ppn, next_idx, 3'b000};
        end
    end

    always_ff @(posedge clk_i) begin
        rdata_q.raw <= mem_rdata_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            global_q <= 1'b0;
        end else begin
            rvalid_q <= mem_rvalid_i;
            if (start_itlb_i || start_dtlb_i) begin
                global_q <= 1'b0;
            end else if (rvalid_q && rdata_q.pte.g) begin
                global_q <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // TLB update
    // ------------------------------------------------------------
    // g of any level above makes the whole mapping global
    always_comb begin
        leaf_pte   = rdata_q.pte;
        leaf_pte.g = rdata_q.pte.g | global_q;
    end

    always_comb begin
        update_o.vpn     = vaddr_q[38:12];
        update_o.asid    = asid_q;
        update_o.is_1g   = (level_i == sv39_pkg::LVL1);
        update_o.is_2m   = (level_i == sv39_pkg::LVL2);
        update_o.content = leaf_pte;
    end

    assign mem_addr_o     = pptr_q;
    assign pte_o          = rdata_q.pte;
    assign rvalid_q_o     = rvalid_q;
    assign update_vaddr_o = vaddr_q;

endmodule

`default_nettype wire

// File: hdl/pte_checker.sv
// PTE decode and fault checks:
// invalid encodings, leaf vs pointer, permission rules,
// superpage alignment

`timescale 1ns/1ps
`default_nettype none

module pte_checker (
    input  sv39_pkg::pte_t       pte_i,
    input  sv39_pkg::ptw_level_e level_i,
    input  logic                 is_instr_i,
    input  logic                 is_store_i,
    input  logic                 mxr_i,
    output logic                 invalid_o,
    output logic                 is_leaf_o,
    output logic                 leaf_fault_o,
    output logic                 misaligned_o
);

    logic load_ok;
    logic store_ok;

    // v clear, or write-only which is reserved
    assign invalid_o = !pte_i.v || (!pte_i.r && pte_i.w);
    // any of r or x marks a leaf, otherwise it points to the next table
    assign is_leaf_o = pte_i.r || pte_i.x;

    // ------------------------------------------------------------
    // permission rules
    // ------------------------------------------------------------
    // executable pages are readable too when MXR is set
    assign load_ok  = pte_i.a && (pte_i.r || (pte_i.x && mxr_i));
    assign store_ok = pte_i.w && pte_i.d;

    always_comb begin
        if (is_instr_i) begin
            leaf_fault_o = !pte_i.x || !pte_i.a;
        end else begin
            leaf_fault_o = !load_ok || (is_store_i && !store_ok);
        end
    end

    // superpages need the low PPN bits cleared
    always_comb begin
        case (level_i)
            sv39_pkg::LVL1: misaligned_o = (pte_i.ppn[17:0] != '0);
            sv39_pkg::LVL2: misaligned_o = (pte_i.ppn[8:0] != '0);
            default:        misaligned_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/ptw_level_ctrl.sv
// Walk depth counter:
// restarts at the root level, descends per pointer PTE, flags the last level

`timescale 1ns/1ps
`default_nettype none

module ptw_level_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 start_i,
    input  logic                 advance_i,
    output sv39_pkg::ptw_level_e level_o,
    output logic                 last_level_o
);

    sv39_pkg::ptw_level_e level_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            level_q <= sv39_pkg::LVL1;
        end else if (start_i) begin
            level_q <= sv39_pkg::LVL1;
        end else if (advance_i) begin
            case (level_q)
                sv39_pkg::LVL1: level_q <= sv39_pkg::LVL2;
                // LVL3 has no lower table, it stays put
                default:        level_q <= sv39_pkg::LVL3;
            endcase
        end
    end

    assign level_o      = level_q;
    // a pointer found here is a page fault
    assign last_level_o = (level_q == sv39_pkg::LVL3);

endmodule

`default_nettype wire

// File: hdl/ptw_tlb_pkg.sv
// TLB-side types of the walker:
// TLB update record and walker state encoding

`default_nettype none

`include "ptw_macros.svh"

package ptw_tlb_pkg;

    typedef struct packed {
        logic [26:0]           vpn;
        logic [`PTW_ASIDW-1:0] asid;
        logic                  is_1g;
        logic                  is_2m;
        sv39_pkg::pte_t        content;
    } tlb_update_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        WAIT_RVALID,
        PROPAGATE_ERROR
    } ptw_state_e;

endpackage

`default_nettype wire

// File: hdl/sv39_pkg.sv
// Sv39 page table types:
// PTE field layout, PTE word union, walk level encoding

`default_nettype none

`include "ptw_macros.svh"

package sv39_pkg;

    // one page table entry as laid out in memory
    typedef struct packed {
        logic [9:0]           reserved;
        logic [`PTW_PPNW-1:0] ppn;
        logic [1:0]           rsw;
        logic                 d;
        logic                 a;
        logic                 g;
        logic                 u;
        logic                 x;
        logic                 w;
        logic                 r;
        logic                 v;
    } pte_t;

    // read data word, seen either raw or as PTE fields
    typedef union packed {
        logic [`PTW_PTEW-1:0] raw;
        pte_t                 pte;
    } pte_word_u;

    // three levels, LVL1 is the root table
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_level_e;

endpackage

`default_nettype wire

// File: include/ptw_macros.svh
// Width macros for the Sv39 page table walker:
// virtual and physical address, PPN, ASID and PTE word

`ifndef PTW_MACROS_SVH
`define PTW_MACROS_SVH

// virtual address width of Sv39
`define PTW_VLEN  39
// physical address width
`define PTW_PLEN  56
// physical page number width
`define PTW_PPNW  44
// address space identifier width
`define PTW_ASIDW 16
// one page table entry
`define PTW_PTEW  64

`endif
